// File: Bender.yml
package:
  name: csr_file

sources:
  # Packages first, then the RTL bottom up
  - verilog/csr_pkg.sv
  - verilog/fp_csr_pkg.sv
  - verilog/csr_access_unit.sv
  - verilog/csr_machine_bank.sv
  - verilog/csr_fp_bank.sv
  - verilog/csr_file.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/csr_file_tb.sv

// File: bench/csr_file_tests.svh
/*
 * Directed tests for the CSR file
 * Reset values, CSR operations, illegal access, traps, FP CSRs
 */
`ifndef CSR_FILE_TESTS_SVH
`define CSR_FILE_TESTS_SVH

task automatic reset_identity();
  test_name = "reset_identity";
  expect_csr("mstatus", CSR_MSTATUS, 32'h0000_1800);  // MPP=M only
  expect_csr("misa", CSR_MISA, 32'h4000_0100);
  expect_csr("mvendorid", CSR_MVENDORID, 32'h0);
  expect_csr("marchid", CSR_MARCHID, 32'h0);
  expect_csr("mimpid", CSR_MIMPID, 32'h1);
  expect_csr("mhartid", CSR_MHARTID, 32'h0);
  check_xlen("frm_out", xlen_t'(FRM_RNE), xlen_t'(frm_out));
endtask

task automatic csr_operations();
  csr_op_e ops[6] = '{CSR_OP_RW, CSR_OP_RS, CSR_OP_RC, CSR_OP_RWI, CSR_OP_RSI, CSR_OP_RCI};
  xlen_t   model;
  xlen_t   value;
  test_name = "csr_operations";
  model = '0;
  foreach (ops[i]) begin
    value = $random(seed);
    if (i >= 3)
      value = value & 32'h1f;  // uimm, zero-extended
    write_csr(CSR_MSCRATCH, ops[i], value);
    case (ops[i])
      CSR_OP_RW, CSR_OP_RWI: model = value;
      CSR_OP_RS, CSR_OP_RSI: model = model | value;
      default:               model = model & ~value;
    endcase
    expect_csr($sformatf("mscratch after %s", ops[i].name()), CSR_MSCRATCH, model);
  end
  // Alignment bits dropped on write
  write_csr(CSR_MTVEC, CSR_OP_RW, '1);
  expect_csr("mtvec all ones", CSR_MTVEC, 32'hffff_fffc);
  write_csr(CSR_MEPC, CSR_OP_RW, '1);
  expect_csr("mepc all ones", CSR_MEPC, 32'hffff_fffe);
endtask

task automatic illegal_access();
  test_name = "illegal_access";
  write_csr(CSR_MSCRATCH, CSR_OP_RW, 32'h0bad_f00d);
  attempt_illegal("write to mhartid", CSR_MHARTID, PRIV_M);
  expect_csr("mhartid kept", CSR_MHARTID, 32'h0);
  attempt_illegal("write to 0x7c0", 12'h7c0, PRIV_M);
  attempt_illegal("user write to mscratch", CSR_MSCRATCH, PRIV_U);
  expect_csr("mscratch kept", CSR_MSCRATCH, 32'h0bad_f00d);
  current_priv = PRIV_U;  // fflags is a user CSR
  write_csr(CSR_FFLAGS, CSR_OP_RW, 32'h0000_000a);
  current_priv = PRIV_M;
  expect_csr("fflags from user", CSR_FFLAGS, 32'h0000_000a);
endtask

task automatic trap_and_return();
  test_name = "trap_and_return";
  write_csr(CSR_MTVEC, CSR_OP_RW, 32'h8000_0100);
  write_csr(CSR_MSTATUS, CSR_OP_RW, 32'h0000_1808);  // MIE set, MPP=M
  check_bit("mie before trap", 1'b1, mstatus_mie);
  current_priv = PRIV_U;
  trap_entry   = 1'b1;
  trap         = '{pc: 32'h0000_2004, cause: 5'd2, val: 32'hdead_0042};
  tick();
  trap_entry   = 1'b0;
  current_priv = PRIV_M;  // Handler runs in M
  #1;
  check_bit("mie after trap", 1'b0, mstatus_mie);
  check_xlen("mpp_out after trap", xlen_t'(PRIV_U), xlen_t'(mpp_out));
  check_xlen("trap_vector", 32'h8000_0100, trap_vector);
  check_xlen("mepc_out", 32'h0000_2004, mepc_out);
  expect_csr("mcause", CSR_MCAUSE, 32'h2);
  expect_csr("mtval", CSR_MTVAL, 32'hdead_0042);
  expect_csr("mstatus in handler", CSR_MSTATUS, 32'h0000_0080);  // MPIE only
  mret = 1'b1;
  tick();
  mret = 1'b0;
  #1;
  check_bit("mie after mret", 1'b1, mstatus_mie);
  check_xlen("mpp_out after mret", xlen_t'(PRIV_M), xlen_t'(mpp_out));
  expect_csr("mstatus after mret", CSR_MSTATUS, 32'h0000_1888);
endtask

task automatic fp_registers();
  test_name = "fp_registers";
  write_csr(CSR_FCSR, CSR_OP_RW, 32'h0000_0075);  // RUP, flags 10101
  check_xlen("frm_out from fcsr", xlen_t'(FRM_RUP), xlen_t'(frm_out));
  check_flags("fflags_out from fcsr", 5'b10101, fflags_out);
  expect_csr("frm", CSR_FRM, 32'h3);
  write_csr(CSR_FFLAGS, CSR_OP_RW, 32'h0);
  tick();
  fflags_we = 1'b1;
  fflags_in = 5'b00001;  // NX
  tick();
  fflags_in = 5'b01000;  // DZ while fflags is read back
  set_req(CSR_FFLAGS, '0, CSR_OP_RS, 1'b0);
  check_xlen("forwarded fflags", 32'h9, rdata);
  check_flags("fflags_out registered", 5'b00001, fflags_out);
  tick();
  fflags_we = 1'b0;
  #1;
  check_flags("accumulated fflags", 5'b01001, fflags_out);
  // Software write against a strobe
  fflags_we = 1'b1;
  fflags_in = 5'b10000;
  set_req(CSR_FFLAGS, 32'h4, CSR_OP_RW, 1'b1);
  check_bit("fflags write legal", 1'b0, illegal_csr);
  tick();
  req.we    = 1'b0;
  fflags_we = 1'b0;
  #1;
  check_flags("write beats strobe", 5'b00100, fflags_out);
endtask

`endif

// File: bench/csr_file_tb.sv
/*
 * Testbench for the machine-mode CSR file
 * Clock, reset, DUT instance, drive and compare tasks,
 * watchdog and the directed test sequence
 */
`timescale 1ns/1ns

module csr_file_tb
  import csr_pkg::*, fp_csr_pkg::*;
;

  localparam int TEST_COUNT      = 5;
  localparam int CYCLES_PER_TEST = 200;

  logic      clk;
  logic      reset_n;
  csr_req_t  req;
  priv_e     current_priv;
  logic      trap_entry;
  trap_req_t trap;
  logic      mret;
  logic      fflags_we;
  fflags_t   fflags_in;
  xlen_t     rdata;
  logic      illegal_csr;
  xlen_t     trap_vector;
  xlen_t     mepc_out;
  logic      mstatus_mie;
  priv_e     mpp_out;
  frm_e      frm_out;
  fflags_t   fflags_out;

  integer seed = 32'hbe6;  // Fixed seed for write data
  string  test_name = "none";

  csr_file csr_file_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // ====================
  // Drive helpers
  // ====================
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic set_req(input csr_addr_t csr_addr, input xlen_t data,
                         input csr_op_e op_code, input logic write);
    req = '{addr: csr_addr, wdata: data, op: op_code, we: write};
    #1;  // Let the read path settle
  endtask

  // ====================
  // Compare tasks
  // ====================
  task automatic check_xlen(input string what, input xlen_t exp, input xlen_t act);
    if (exp !== act)
      report_failure($sformatf("mismatch [%s] %s: expected 0x%08h, actual 0x%08h",
                               test_name, what, exp, act));
  endtask

  task automatic check_flags(input string what, input fflags_t exp, input fflags_t act);
    if (exp !== act)
      report_failure($sformatf("mismatch [%s] %s: expected %05b, actual %05b",
                               test_name, what, exp, act));
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act)
      report_failure($sformatf("mismatch [%s] %s: expected %b, actual %b",
                               test_name, what, exp, act));
  endtask

  // Read only, so illegal_csr must stay low
  task automatic expect_csr(input string what, input csr_addr_t csr_addr, input xlen_t exp);
    tick();
    set_req(csr_addr, '0, CSR_OP_RS, 1'b0);
    check_bit({what, " illegal"}, 1'b0, illegal_csr);
    check_xlen(what, exp, rdata);
  endtask

  // Legal write, committed at the next edge
  task automatic write_csr(input csr_addr_t csr_addr, input csr_op_e op_code,
                           input xlen_t data);
    tick();
    set_req(csr_addr, data, op_code, 1'b1);
    check_bit("legal write accepted", 1'b0, illegal_csr);
    tick();
    req.we = 1'b0;
  endtask

  task automatic attempt_illegal(input string what, input csr_addr_t csr_addr,
                                 input priv_e priv);
    tick();
    current_priv = priv;
    set_req(csr_addr, $random(seed), CSR_OP_RW, 1'b1);
    check_bit(what, 1'b1, illegal_csr);  // Flagged in the same cycle
    tick();
    req.we       = 1'b0;
    current_priv = PRIV_M;
  endtask

  `include "csr_file_tests.svh"

  // Watchdog sized from the test count
  initial begin
    repeat (TEST_COUNT * CYCLES_PER_TEST) @(posedge clk);
    report_failure("Timeout, the test sequence did not finish within the cycle budget");
  end

  // ====================
  // Test sequence
  // ====================
  initial begin
    reset_n      = 1'b0;
    req          = '{addr: '0, wdata: '0, op: CSR_OP_RS, we: 1'b0};
    current_priv = PRIV_M;
    trap_entry   = 1'b0;
    trap         = '0;
    mret         = 1'b0;
    fflags_we    = 1'b0;
    fflags_in    = '0;
    repeat (3) @(posedge clk);
    #1 reset_n = 1'b1;

    reset_identity();
    csr_operations();
    illegal_access();
    trap_and_return();
    fp_registers();

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+bench
verilog/csr_pkg.sv
verilog/fp_csr_pkg.sv
verilog/csr_access_unit.sv
verilog/csr_machine_bank.sv
verilog/csr_fp_bank.sv
verilog/csr_file.sv
bench/csr_file_tb.sv

// File: verilog/csr_access_unit.sv
/*
 * CSR access unit
 * Decodes the address, checks existence, privilege and read-only access,
 * muxes read data and builds the qualified write for both banks
 */
`timescale 1ns/1ns

module csr_access_unit
  import csr_pkg::*, fp_csr_pkg::*;
(
  input  csr_req_t    req,
  input  priv_e       current_priv,
  input  logic        trap_entry,
  input  logic        mret,
  input  mach_state_t mach,
  input  fp_state_t   fp,
  output xlen_t       rdata,
  output logic        illegal_csr,
  output csr_wr_t     wr
);

  csr_sel_e   sel;
  logic [1:0] addr_priv;  // Lowest privilege allowed
  logic       priv_low;
  logic       read_only;
  xlen_t      wr_value;

  // ====================
  // Decode
  // ====================
  always_comb begin
    case (req.addr)
      CSR_MSTATUS:   sel = SEL_MSTATUS;
      CSR_MISA:      sel = SEL_MISA;
      CSR_MTVEC:     sel = SEL_MTVEC;
      CSR_MSCRATCH:  sel = SEL_MSCRATCH;
      CSR_MEPC:      sel = SEL_MEPC;
      CSR_MCAUSE:    sel = SEL_MCAUSE;
      CSR_MTVAL:     sel = SEL_MTVAL;
      CSR_MVENDORID: sel = SEL_MVENDORID;
      CSR_MARCHID:   sel = SEL_MARCHID;
      CSR_MIMPID:    sel = SEL_MIMPID;
      CSR_MHARTID:   sel = SEL_MHARTID;
      CSR_FFLAGS:    sel = SEL_FFLAGS;
      CSR_FRM:       sel = SEL_FRM;
      CSR_FCSR:      sel = SEL_FCSR;
      default:       sel = SEL_NONE;  // Not implemented
    endcase
  end

  assign addr_priv = req.addr[9:8];
  assign priv_low  = current_priv < addr_priv;
  // Top address bits 11 mark the read-only space, misa is hardwired here
  assign read_only = (req.addr[11:10] == 2'b11) || (sel == SEL_MISA);

  // Only an attempted write can be illegal
  assign illegal_csr = req.we && ((sel == SEL_NONE) || priv_low || read_only);

  // ====================
  // Read mux
  // ====================
  always_comb begin
    case (sel)
      SEL_MSTATUS: rdata = {19'b0, mach.mpp, 3'b0, mach.mpie, 3'b0, mach.mie, 3'b0};
      SEL_MISA:      rdata = MISA_VALUE;
      SEL_MTVEC:     rdata = mach.mtvec;
      SEL_MSCRATCH:  rdata = mach.mscratch;
      SEL_MEPC:      rdata = mach.mepc;
      SEL_MCAUSE:    rdata = mach.mcause;
      SEL_MTVAL:     rdata = mach.mtval;
      SEL_MVENDORID: rdata = MVENDORID_VALUE;
      SEL_MARCHID:   rdata = MARCHID_VALUE;
      SEL_MIMPID:    rdata = MIMPID_VALUE;
      SEL_MHARTID:   rdata = MHARTID_VALUE;
      SEL_FFLAGS:    rdata = {{(XLEN-5){1'b0}}, fp.fflags_view};  // Forwarded flags
      SEL_FRM:       rdata = {{(XLEN-3){1'b0}}, fp.frm};
      SEL_FCSR:      rdata = {{(XLEN-8){1'b0}}, fp};              // frm above flags
      default:       rdata = '0;
    endcase
  end

  // ====================
  // Write value
  // ====================
  always_comb begin
    case (req.op)
      CSR_OP_RW, CSR_OP_RWI: wr_value = req.wdata;
      CSR_OP_RS, CSR_OP_RSI: wr_value = rdata | req.wdata;   // Set bits
      CSR_OP_RC, CSR_OP_RCI: wr_value = rdata & ~req.wdata;  // Clear bits
      default:               wr_value = rdata;                // Reserved funct3
    endcase
  end

  // Trap and return take the cycle, an illegal write does nothing at all
  assign wr = '{en:    req.we && !illegal_csr && !trap_entry && !mret,
                sel:   sel,
                value: wr_value};

  // Banks never see a write aimed at a hardwired or missing register
  always_comb begin
    assert #0 (!(wr.en && (wr.sel inside {SEL_NONE, SEL_MISA, SEL_MVENDORID,
                                          SEL_MARCHID, SEL_MIMPID, SEL_MHARTID})))
      else $error("CSR write issued to read-only or missing register %0s", wr.sel.name());
  end

endmodule

// File: verilog/csr_file.sv
/*
 * Machine-mode CSR file, top level
 * Access unit in front of the machine trap bank and the FP bank
 */
`timescale 1ns/1ns

module csr_file
  import csr_pkg::*, fp_csr_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  // Instruction side
  input  csr_req_t  req,
  input  priv_e     current_priv,
  output xlen_t     rdata,
  output logic      illegal_csr,
  // Trap and return
  input  logic      trap_entry,
  input  trap_req_t trap,
  input  logic      mret,
  output xlen_t     trap_vector,
  output xlen_t     mepc_out,
  output logic      mstatus_mie,
  output priv_e     mpp_out,
  // FPU side
  input  logic      fflags_we,
  input  fflags_t   fflags_in,
  output frm_e      frm_out,
  output fflags_t   fflags_out
);

  mach_state_t mach;  // Machine bank state to the read mux
  fp_state_t   fp;
  csr_wr_t     wr;    // Shared write bus

  csr_access_unit csr_access_unit_inst (
    .req          (req),
    .current_priv (current_priv),
    .trap_entry   (trap_entry),
    .mret         (mret),
    .mach         (mach),
    .fp           (fp),
    .rdata        (rdata),
    .illegal_csr  (illegal_csr),
    .wr           (wr)
  );

  csr_machine_bank csr_machine_bank_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .wr           (wr),
    .trap_entry   (trap_entry),
    .trap         (trap),
    .mret         (mret),
    .current_priv (current_priv),
    .mach         (mach),
    .trap_vector  (trap_vector),
    .mepc_out     (mepc_out),
    .mstatus_mie  (mstatus_mie),
    .mpp_out      (mpp_out)
  );

  csr_fp_bank csr_fp_bank_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .wr         (wr),
    .fflags_we  (fflags_we),
    .fflags_in  (fflags_in),
    .fp         (fp),
    .frm_out    (frm_out),
    .fflags_out (fflags_out)
  );

endmodule

// File: verilog/csr_fp_bank.sv
/*
 * Floating-point CSR bank
 * fflags and frm with sticky FPU flag accumulation
 * and a same-cycle forwarded flags view
 */
`timescale 1ns/1ns

module csr_fp_bank
  import csr_pkg::*, fp_csr_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  csr_wr_t   wr,
  input  logic      fflags_we,
  input  fflags_t   fflags_in,
  output fp_state_t fp,
  output frm_e      frm_out,
  output fflags_t   fflags_out
);

  fflags_t fflags_q;
  frm_e    frm_q;
  fflags_t flags_fwd;
  logic    flags_wr;  // CSR write hits the flags
  logic    frm_wr;

  assign flags_wr = wr.en && (wr.sel == SEL_FFLAGS || wr.sel == SEL_FCSR);
  assign frm_wr   = wr.en && (wr.sel == SEL_FRM || wr.sel == SEL_FCSR);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      fflags_q <= '0;
      frm_q    <= FRM_RNE;
    end else begin
      if (frm_wr)
        frm_q <= frm_e'((wr.sel == SEL_FCSR) ? wr.value[7:5] : wr.value[2:0]);
      // Software write wins over the FPU in the same cycle
      if (flags_wr)
        fflags_q <= fflags_t'(wr.value[4:0]);
      else if (fflags_we)
        fflags_q <= fflags_t'(fflags_q | fflags_in);  // Sticky OR
    end
  end

  // Read view sees flags retiring this cycle
  assign flags_fwd  = fflags_we ? fflags_t'(fflags_q | fflags_in) : fflags_q;
  assign fp         = '{frm: frm_q, fflags_view: flags_fwd};
  assign frm_out    = frm_q;
  assign fflags_out = fflags_q;  // Registered, not forwarded

  a_fflags_known: assert property (
    @(posedge clk) disable iff (!reset_n) fflags_we |-> !$isunknown(fflags_in)
  ) else $error("FPU flags unknown while fflags_we is high");

endmodule

// File: verilog/csr_machine_bank.sv
/*
 * Machine trap bank
 * Holds mstatus MIE/MPIE/MPP and the machine trap registers,
 * updated by trap entry, MRET and CSR writes in that priority
 */
`timescale 1ns/1ns

module csr_machine_bank
  import csr_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  csr_wr_t     wr,
  input  logic        trap_entry,
  input  trap_req_t   trap,
  input  logic        mret,
  input  priv_e       current_priv,
  output mach_state_t mach,
  output xlen_t       trap_vector,
  output xlen_t       mepc_out,
  output logic        mstatus_mie,
  output priv_e       mpp_out
);

  priv_e wr_mpp;

  // MPP is WARL, only U and M are held
  assign wr_mpp = (wr.value[12:11] == 2'b00) ? PRIV_U : PRIV_M;

  // ====================
  // Register update
  // ====================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mach.mie      <= 1'b0;
      mach.mpie     <= 1'b0;
      mach.mpp      <= PRIV_M;  // Come out of reset as if trapped from M
      mach.mtvec    <= '0;
      mach.mscratch <= '0;
      mach.mepc     <= '0;
      mach.mcause   <= '0;
      mach.mtval    <= '0;
    end else if (trap_entry) begin
      mach.mepc   <= trap.pc;
      mach.mcause <= {{(XLEN-5){1'b0}}, trap.cause};  // Exceptions only, bit 31 clear
      mach.mtval  <= trap.val;
      mach.mpie   <= mach.mie;
      mach.mie    <= 1'b0;       // Handler starts masked
      mach.mpp    <= current_priv;
    end else if (mret) begin
      mach.mie  <= mach.mpie;
      mach.mpie <= 1'b1;
      mach.mpp  <= PRIV_M;
    end else if (wr.en) begin
      case (wr.sel)
        SEL_MSTATUS: begin
          mach.mie  <= wr.value[3];
          mach.mpie <= wr.value[7];
          mach.mpp  <= wr_mpp;
        end
        SEL_MTVEC:    mach.mtvec    <= {wr.value[XLEN-1:2], 2'b00};  // Direct mode, aligned
        SEL_MSCRATCH: mach.mscratch <= wr.value;
        SEL_MEPC:     mach.mepc     <= {wr.value[XLEN-1:1], 1'b0};   // IALIGN 16
        SEL_MCAUSE:   mach.mcause   <= wr.value;
        SEL_MTVAL:    mach.mtval    <= wr.value;
        default: begin
          // FP registers belong to the other bank
        end
      endcase
    end
  end

  // ====================
  // Core-facing outputs
  // ====================
  assign trap_vector = mach.mtvec;  // No delegation, always mtvec
  assign mepc_out    = mach.mepc;
  assign mstatus_mie = mach.mie;
  assign mpp_out     = mach.mpp;

  // The core retires at most one of these per cycle
  a_trap_mret_excl: assert property (
    @(posedge clk) disable iff (!reset_n) !(trap_entry && mret)
  ) else $error("trap_entry and mret asserted in the same cycle");

endmodule

// File: verilog/csr_pkg.sv
/*
 * Machine-mode CSR definitions for RV32
 * Address map, operation and privilege encodings, decoded register
 * select, request and write bus structs, hardwired ID values
 */
package csr_pkg;

  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [11:0]     csr_addr_t;

  // ====================
  // CSR address map
  // ====================
  localparam csr_addr_t CSR_FFLAGS    = 12'h001;
  localparam csr_addr_t CSR_FRM       = 12'h002;
  localparam csr_addr_t CSR_FCSR      = 12'h003;
  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MISA      = 12'h301;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MTVAL     = 12'h343;
  localparam csr_addr_t CSR_MVENDORID = 12'hF11;
  localparam csr_addr_t CSR_MARCHID   = 12'hF12;
  localparam csr_addr_t CSR_MIMPID    = 12'hF13;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;

  // Hardwired identity registers
  localparam xlen_t MISA_VALUE      = 32'h4000_0100; // MXL=1, I extension
  localparam xlen_t MVENDORID_VALUE = 32'h0;          // Non-commercial
  localparam xlen_t MARCHID_VALUE   = 32'h0;
  localparam xlen_t MIMPID_VALUE    = 32'h1;
  localparam xlen_t MHARTID_VALUE   = 32'h0;          // Single hart

  // funct3 of the CSR instructions
  typedef enum logic [2:0] {
    CSR_OP_RW  = 3'd1,
    CSR_OP_RS  = 3'd2,
    CSR_OP_RC  = 3'd3,
    CSR_OP_RWI = 3'd5,
    CSR_OP_RSI = 3'd6,
    CSR_OP_RCI = 3'd7
  } csr_op_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_e;

  // Decoded register, one per implemented CSR
  typedef enum logic [3:0] {
    SEL_NONE, SEL_MSTATUS, SEL_MTVEC, SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE,
    SEL_MTVAL, SEL_FFLAGS, SEL_FRM, SEL_FCSR,
    SEL_MISA, SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID // Read-only group
  } csr_sel_e;

  // ====================
  // Buses
  // ====================
  typedef struct packed {
    csr_addr_t addr;
    xlen_t     wdata;  // rs1 or zero-extended uimm
    csr_op_e   op;
    logic      we;
  } csr_req_t;

  typedef struct packed {
    logic     en;     // Already qualified, banks just obey
    csr_sel_e sel;
    xlen_t    value;  // Result of the read-modify-write
  } csr_wr_t;

  typedef struct packed {
    xlen_t      pc;
    logic [4:0] cause;
    xlen_t      val;
  } trap_req_t;

  typedef struct packed {
    logic  mie;
    logic  mpie;
    priv_e mpp;
    xlen_t mtvec;
    xlen_t mscratch;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mtval;
  } mach_state_t;

endpackage

// File: verilog/fp_csr_pkg.sv
/*
 * Floating-point CSR types
 * Exception flags, rounding modes and the FP bank state view
 */
package fp_csr_pkg;

  // Accrued exception flags, NV in the top bit
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } fflags_t;

  typedef enum logic [2:0] {
    FRM_RNE = 3'd0,  // Nearest, ties to even
    FRM_RTZ = 3'd1,
    FRM_RDN = 3'd2,
    FRM_RUP = 3'd3,
    FRM_RMM = 3'd4,  // Nearest, ties to max magnitude
    FRM_DYN = 3'd7
  } frm_e;

  // Laid out as fcsr bits 7:0
  typedef struct packed {
    frm_e    frm;
    fflags_t fflags_view;  // Includes flags arriving this cycle
  } fp_state_t;

endpackage
